/* test/mem_vectors.txt */
// kind addr_or_sig pattern expected, hex, one transaction per line
// kinds 1 instr rd, 2 evict, 3 data rd, 4 table load, 5 accel wr, 6 accel rd, 7 instr+data, 8 data+accel
2 00000040 cafe0001 00000000   // evict block 1, bank 1
3 00000040 00000000 cafe0001
1 00001040 00000000 cafe0001   // aliased by 4 KB
2 000003c0 beef000f 00000000   // block 15, bank 3
2 00000e80 1234003a 00000000   // block 58, bank 2
7 000003c0 00000000 beef000f   // data wins over instr
4 00000002 00000010 00000000   // sig 2 starts at block 16
5 00000002 a0000000 00000000   // blocks 16..19, all banks
6 00000002 00000000 00000000
3 00000440 00000000 a0000001   // block 17
3 000004c0 00000000 a0000003   // block 19
4 00000005 0000002c 00000000   // sig 5 starts at block 44
2 00000b00 55aa002c 00000000
2 00000b40 55aa002d 00000000
2 00000b80 55aa002e 00000000
2 00000bc0 55aa002f 00000000
6 00000005 00000000 00000000   // reads the evicted blocks
8 00000e80 00000002 1234003a   // chunk of sig 2 before data
1 00000400 00000000 a0000000   // block 16
0 00000000 00000000 00000000   // end

/* list.f */
+incdir+hw
hw/memPkg.sv
hw/bankIf.sv
hw/sigTable.sv
hw/memArb.sv
hw/bankRouter.sv
hw/memBank.sv
hw/bankMerge.sv
hw/memSubsystem.sv
test/memSubsystem_sva.sv
test/memSubsystem_tb.sv

/* run.sh */
#!/bin/sh
# build and run the memSubsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal --top-module memSubsystem_tb -f list.f -o simv
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
    exit 0
fi
exit 1

/* test/memSubsystem_tb.sv */
`timescale 1ns/100ps
`include "memArb_consts.svh"

module memSubsystem_tb import memPkg::*; ();

    localparam int TIMEOUT = 100;        // cycles per wait
    localparam int MAX_VEC = 32;
    localparam int R_INSTR = 0;          // bit positions in respVec
    localparam int R_DATA  = 1;
    localparam int R_EVICT = 2;
    localparam int R_ACRD  = 3;
    localparam int R_ACWR  = 4;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    tableWr;
    logic [`SIG_BITS-1:0]    tableSig, sigNum;
    logic [`BLKNUM_BITS-1:0] tableStart;
    logic                    instrReq, instrBlkValid;
    logic [31:0]             instrAddr, dataAddr;
    logic                    dataReq, dataEvictReq, dataBlkValid, dataEvictAck;
    logic                    accelRd, accelWr, accelRdBlkDone, accelWrBlkDone, accelChunkDone;
    blk_t                    instrBlk, dataWrBlk, dataBlk, accelWrBlk, accelRdBlk;
    logic [5:0]              respVec;

    logic [31:0]             vecMem [4*MAX_VEC];    // kind, a, b, c per line
    blk_t                    shadow [64];           // indexed by addr[11:6]
    logic [`BLKNUM_BITS-1:0] tblCopy [8];           // start blocks as loaded
    int                      mismatches, failures;
    logic                    timedOut;

    memSubsystem dut (.*);

    always #20 clk = ~clk;   // 40 ns period

    assign respVec = {accelChunkDone, accelWrBlkDone, accelRdBlkDone,
                      dataEvictAck, dataBlkValid, instrBlkValid};

    function automatic blk_t fillBlk(input logic [31:0] pat);
        return {16{pat}};
    endfunction

    function automatic logic [5:0] blkIndex(input logic [31:0] addr);
        return addr[11:6];   // 4 KB alias
    endfunction

    // base plus 64 bytes per block of start + offset
    function automatic logic [31:0] chunkAddr(input logic [`SIG_BITS-1:0] sig, input int off);
        return `SIG_BASE + ((32'(tblCopy[sig]) + 32'(off)) << 6);
    endfunction

    task automatic compareBlk(input string name, input blk_t exp, input blk_t act);
        if (act !== exp) begin
            $display("Mismatch %s expected %h actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic expectFlag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch %s expected %b actual %b", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic checkRead(input string name, input logic [31:0] addr,
                             input logic [31:0] pat, input blk_t act);
        compareBlk({name, " file"}, fillBlk(pat), act);
        compareBlk({name, " shadow"}, shadow[blkIndex(addr)], act);
    endtask

    // sample at negedge, guard flags a response that should have lost
    task automatic waitResp(input int idx, input int guard, input string what);
        if (timedOut) return;
        for (int n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            if (guard >= 0 && respVec[guard] && !respVec[idx]) begin
                $display("%s: a lower priority request was answered first", what);
                failures++;
            end
            if (respVec[idx]) return;
        end
        $display("Timeout: %s never came", what);
        failures++;
        timedOut = 1'b1;
    endtask

    task automatic readChunk(input logic [`SIG_BITS-1:0] sig, input int guard, input string name);
        for (int i = 0; i < `CHUNK_BLKS; i++) begin
            waitResp(R_ACRD, guard, {name, " accelRdBlkDone"});
            if (timedOut) return;
            compareBlk({name, " chunk"}, shadow[blkIndex(chunkAddr(sig, i))], accelRdBlk);
            expectFlag({name, " accelChunkDone"}, i == `CHUNK_BLKS - 1, accelChunkDone);
        end
        @(posedge clk);
        accelRd <= 1'b0;
    endtask

    task automatic writeChunk(input logic [`SIG_BITS-1:0] sig, input logic [31:0] pat,
                              input string name);
        for (int i = 0; i < `CHUNK_BLKS; i++) begin
            waitResp(R_ACWR, -1, {name, " accelWrBlkDone"});
            if (timedOut) return;
            shadow[blkIndex(chunkAddr(sig, i))] = fillBlk(pat + 32'(i));   // block i holds pat+i
            expectFlag({name, " accelChunkDone"}, i == `CHUNK_BLKS - 1, accelChunkDone);
            @(posedge clk);
            if (i == `CHUNK_BLKS - 1) accelWr <= 1'b0;
            else accelWrBlk <= fillBlk(pat + 32'(i + 1));   // next block's data
        end
    endtask

    initial begin
        int          v;
        logic [31:0] kind, a, b, c;
        string       name;
        rst = 1'b1;
        tableWr = 1'b0;
        tableSig = '0;
        tableStart = '0;
        sigNum = '0;
        instrReq = 1'b0;
        instrAddr = '0;
        dataReq = 1'b0;
        dataEvictReq = 1'b0;
        dataAddr = '0;
        dataWrBlk = '0;
        accelRd = 1'b0;
        accelWr = 1'b0;
        accelWrBlk = '0;
        mismatches = 0;
        failures = 0;
        timedOut = 1'b0;
        $readmemh("test/mem_vectors.txt", vecMem);

        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (4) begin   // quiet with nothing requested
            @(negedge clk);
            if (respVec !== '0) begin
                $display("A response pulsed while no request was pending");
                failures++;
            end
        end

        v = 0;
        while (!timedOut && v < MAX_VEC && vecMem[4*v] != 32'h0) begin
            kind = vecMem[4*v];
            a    = vecMem[4*v + 1];
            b    = vecMem[4*v + 2];
            c    = vecMem[4*v + 3];
            name = $sformatf("vec%0d", v);
            @(posedge clk);
            case (kind)
                1: begin   // instruction read
                    instrAddr <= a;
                    instrReq  <= 1'b1;
                    waitResp(R_INSTR, -1, {name, " instrBlkValid"});
                    checkRead({name, " instr"}, a, c, instrBlk);
                    @(posedge clk);
                    instrReq <= 1'b0;
                end
                2: begin   // data evict
                    dataAddr     <= a;
                    dataWrBlk    <= fillBlk(b);
                    dataEvictReq <= 1'b1;
                    waitResp(R_EVICT, -1, {name, " dataEvictAck"});
                    shadow[blkIndex(a)] = fillBlk(b);
                    @(posedge clk);
                    dataEvictReq <= 1'b0;
                end
                3: begin   // data read
                    dataAddr <= a;
                    dataReq  <= 1'b1;
                    waitResp(R_DATA, -1, {name, " dataBlkValid"});
                    checkRead({name, " data"}, a, c, dataBlk);
                    @(posedge clk);
                    dataReq <= 1'b0;
                end
                4: begin   // table load
                    tableWr    <= 1'b1;
                    tableSig   <= a[`SIG_BITS-1:0];
                    tableStart <= b[`BLKNUM_BITS-1:0];
                    tblCopy[a[`SIG_BITS-1:0]] = b[`BLKNUM_BITS-1:0];
                    @(posedge clk);
                    tableWr <= 1'b0;
                end
                5: begin   // accel chunk write
                    sigNum     <= a[`SIG_BITS-1:0];
                    accelWrBlk <= fillBlk(b);
                    accelWr    <= 1'b1;
                    writeChunk(a[`SIG_BITS-1:0], b, name);
                end
                6: begin   // accel chunk read
                    sigNum  <= a[`SIG_BITS-1:0];
                    accelRd <= 1'b1;
                    readChunk(a[`SIG_BITS-1:0], -1, name);
                end
                7: begin   // instr and data together, data first
                    instrAddr <= a;
                    dataAddr  <= a;
                    instrReq  <= 1'b1;
                    dataReq   <= 1'b1;
                    waitResp(R_DATA, R_INSTR, {name, " dataBlkValid"});
                    checkRead({name, " data"}, a, c, dataBlk);
                    @(posedge clk);
                    dataReq <= 1'b0;
                    waitResp(R_INSTR, -1, {name, " instrBlkValid"});
                    checkRead({name, " instr"}, a, c, instrBlk);
                    @(posedge clk);
                    instrReq <= 1'b0;
                end
                8: begin   // data and accel together, chunk first
                    dataAddr <= a;
                    dataReq  <= 1'b1;
                    sigNum   <= b[`SIG_BITS-1:0];
                    accelRd  <= 1'b1;
                    readChunk(b[`SIG_BITS-1:0], R_DATA, name);
                    waitResp(R_DATA, -1, {name, " dataBlkValid"});
                    checkRead({name, " data"}, a, c, dataBlk);
                    @(posedge clk);
                    dataReq <= 1'b0;
                end
                default: begin
                    $display("Unknown vector kind %0d in line %0d", kind, v);
                    failures++;
                end
            endcase
            v++;
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* test/memSubsystem_sva.sv */
`timescale 1ns/100ps

module memSubsystem_sva import memPkg::*; (
    input logic   clk,
    input logic   rst,
    input logic   instrBlkValid,
    input logic   dataBlkValid,
    input logic   dataEvictAck,
    input logic   accelRdBlkDone,
    input logic   accelWrBlkDone,
    input logic   accelChunkDone,
    input memOp_t memOp,           // internal shared port
    input logic   memDone
);

    logic [4:0] resp;

    assign resp = {accelWrBlkDone, accelRdBlkDone, dataEvictAck, dataBlkValid, instrBlkValid};

    // one requester answered per cycle
    onePulse: assert property (@(posedge clk) disable iff (rst) $onehot0(resp))
        else $error("two response pulses in one cycle");

    evictPulse: assert property (@(posedge clk) disable iff (rst) dataEvictAck |=> !dataEvictAck)
        else $error("dataEvictAck longer than one cycle");

    // op held until the bank answers
    opHeld: assert property (@(posedge clk) disable iff (rst)
        (memOp != OP_IDLE && !memDone) |=> $stable(memOp))
        else $error("memOp changed before memDone");

    quietInReset: assert property (@(posedge clk) rst |-> (resp == '0 && !accelChunkDone))
        else $error("response active during reset");

endmodule

bind memSubsystem memSubsystem_sva sva (.*);

/* hw/memSubsystem.sv */
`timescale 1ns/100ps
`include "memArb_consts.svh"

module memSubsystem import memPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    // signal table load
    input  logic                    tableWr,
    input  logic [`SIG_BITS-1:0]    tableSig,
    input  logic [`BLKNUM_BITS-1:0] tableStart,
    input  logic [`SIG_BITS-1:0]    sigNum,
    // instruction cache
    input  logic                    instrReq,
    input  logic [31:0]             instrAddr,
    output blk_t                    instrBlk,
    output logic                    instrBlkValid,
    // data cache
    input  logic                    dataReq,
    input  logic                    dataEvictReq,
    input  logic [31:0]             dataAddr,
    input  blk_t                    dataWrBlk,
    output blk_t                    dataBlk,
    output logic                    dataBlkValid,
    output logic                    dataEvictAck,
    // accelerator buffer
    input  logic                    accelRd,
    input  logic                    accelWr,
    input  blk_t                    accelWrBlk,
    output blk_t                    accelRdBlk,
    output logic                    accelRdBlkDone,
    output logic                    accelWrBlkDone,
    output logic                    accelChunkDone
);

    logic [31:0] blkAddr;      // from sigTable
    logic        lastBlk;
    logic        blkStep;
    logic        chunkClear;
    memOp_t      memOp;        // shared block port
    logic [31:0] memAddr;
    blk_t        memWrData;
    logic        memDone;
    logic        memRdValid;
    blk_t        memRdData;

    bankIf banks [`NUM_BANKS] ();   // one per bank

    memArb arb (.*);

    sigTable sigTbl (
        .clk, .rst, .tableWr, .tableSig, .tableStart, .sigNum,
        .blkStep, .chunkClear, .blkAddr, .lastBlk
    );

    bankRouter router (.memOp, .memAddr, .memWrData, .banks(banks));

    for (genvar b = 0; b < `NUM_BANKS; b++) begin : gBank
        memBank bank (.clk, .rst, .port(banks[b]));
    end

    bankMerge merge (.banks(banks), .memDone, .memRdValid, .memRdData);

endmodule

/* hw/bankMerge.sv */
`timescale 1ns/100ps
`include "memArb_consts.svh"

module bankMerge import memPkg::*; (
    bankIf.merge  banks [`NUM_BANKS],
    output logic  memDone,
    output logic  memRdValid,
    output blk_t  memRdData
);

    logic [`NUM_BANKS-1:0] doneVec;
    logic [`NUM_BANKS-1:0] validVec;
    blk_t                  rdDataArr [`NUM_BANKS];

    // flatten the interface array
    for (genvar b = 0; b < `NUM_BANKS; b++) begin : gCollect
        assign doneVec[b]   = banks[b].done;
        assign validVec[b]  = banks[b].rdValid;
        assign rdDataArr[b] = banks[b].rdData;
    end

    // one access in flight, so at most one bank pulses
    assign memDone    = |doneVec;
    assign memRdValid = |validVec;

    always_comb begin
        memRdData = '0;
        for (int i = 0; i < `NUM_BANKS; i++) begin
            if (validVec[i]) memRdData = rdDataArr[i];   // data of the valid bank
        end
    end

endmodule

/* hw/memBank.sv */
`timescale 1ns/100ps
`include "memArb_consts.svh"

module memBank import memPkg::*; (
    input  logic clk,
    input  logic rst,
    bankIf.bank  port
);

    localparam int ROW_BITS = $clog2(`BANK_ROWS);
    localparam int CNT_BITS = $clog2(`BANK_LAT + 1);

    blk_t                mem [`BANK_ROWS];   // undefined after reset
    logic                busy;
    logic                isWrite;
    logic [CNT_BITS-1:0] cnt;                // cycles since start
    logic [ROW_BITS-1:0] rowReg;
    logic                start;

    assign start     = !busy && (port.op != OP_IDLE);
    assign port.done = busy && (cnt == CNT_BITS'(`BANK_LAT));

    // access timer
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy         <= 1'b0;
            isWrite      <= 1'b0;
            cnt          <= '0;
            port.rdValid <= 1'b0;
        end else begin
            port.rdValid <= 1'b0;                 // pulse
            if (start) begin
                busy    <= 1'b1;
                cnt     <= CNT_BITS'(1);
                isWrite <= (port.op == OP_WRITE);
            end else if (port.done) begin
                busy         <= 1'b0;             // idle again next cycle
                port.rdValid <= !isWrite;         // read data one cycle after done
            end else if (busy) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // storage and read data path
    always_ff @(posedge clk) begin
        if (start) begin
            rowReg <= port.row;
        end
        if (port.done && isWrite) begin
            mem[rowReg] <= port.wrData;           // wrData held by the arbiter until done
        end
        if (port.done && !isWrite) begin
            port.rdData <= mem[rowReg];
        end
    end

endmodule

/* hw/bankRouter.sv */
`timescale 1ns/100ps
`include "memArb_consts.svh"

module bankRouter import memPkg::*; (
    input  memOp_t      memOp,
    input  logic [31:0] memAddr,
    input  blk_t        memWrData,
    bankIf.router       banks [`NUM_BANKS]
);

    localparam int SEL_BITS = $clog2(`NUM_BANKS);
    localparam int ROW_BITS = $clog2(`BANK_ROWS);

    logic [SEL_BITS-1:0] bankSel;
    logic [ROW_BITS-1:0] row;

    // addr[7:6] picks the bank, addr[11:8] the row
    // upper bits ignored so 4 KB aliases
    assign bankSel = memAddr[6 +: SEL_BITS];
    assign row     = memAddr[6 + SEL_BITS +: ROW_BITS];

    for (genvar b = 0; b < `NUM_BANKS; b++) begin : gRoute
        // only the selected bank sees a live op
        assign banks[b].op     = (int'(bankSel) == b) ? memOp : OP_IDLE;
        assign banks[b].row    = row;          // harmless while op is idle
        assign banks[b].wrData = memWrData;
    end

endmodule

/* hw/memArb.sv */
`timescale 1ns/100ps

module memArb import memPkg::*; (
    input  logic        clk,
    input  logic        rst,

    // instruction cache, lowest priority
    input  logic        instrReq,
    input  logic [31:0] instrAddr,
    output blk_t        instrBlk,
    output logic        instrBlkValid,

    // data cache
    input  logic        dataReq,
    input  logic        dataEvictReq,     // goes ahead of dataReq
    input  logic [31:0] dataAddr,
    input  blk_t        dataWrBlk,
    output blk_t        dataBlk,
    output logic        dataBlkValid,
    output logic        dataEvictAck,

    // accelerator buffer, highest priority
    input  logic        accelRd,          // held for the whole chunk
    input  logic        accelWr,
    input  blk_t        accelWrBlk,
    output blk_t        accelRdBlk,
    output logic        accelRdBlkDone,
    output logic        accelWrBlkDone,
    output logic        accelChunkDone,

    // signal table
    input  logic [31:0] blkAddr,
    input  logic        lastBlk,
    output logic        blkStep,
    output logic        chunkClear,

    // shared block port
    output memOp_t      memOp,
    output logic [31:0] memAddr,
    output blk_t        memWrData,
    input  logic        memDone,
    input  logic        memRdValid,
    input  blk_t        memRdData
);

    localparam logic [31:0] BLK_MASK = 32'hFFFF_FFC0;   // 64 byte alignment

    arbState_t state, nextState;

    // read data fans out to every requester, valids qualify it
    assign instrBlk   = memRdData;
    assign dataBlk    = memRdData;
    assign accelRdBlk = memRdData;

    always_comb begin
        nextState      = state;
        memOp          = OP_IDLE;
        memAddr        = 32'h0;
        memWrData      = '0;
        instrBlkValid  = 1'b0;
        dataBlkValid   = 1'b0;
        dataEvictAck   = 1'b0;
        accelRdBlkDone = 1'b0;
        accelWrBlkDone = 1'b0;
        accelChunkDone = 1'b0;
        blkStep        = 1'b0;
        chunkClear     = 1'b0;

        case (state)
            ST_IDLE: begin
                // fixed priority grant
                if (accelRd) begin
                    nextState = ST_ACCEL_RD;
                end else if (accelWr) begin
                    nextState = ST_ACCEL_WR;
                end else if (dataEvictReq) begin
                    nextState = ST_DATA_WR;
                end else if (dataReq) begin
                    nextState = ST_DATA_RD;
                end else if (instrReq) begin
                    nextState = ST_INSTR_RD;
                end
            end

            ST_INSTR_RD: begin
                memOp   = OP_READ;
                memAddr = instrAddr & BLK_MASK;
                if (memDone) nextState = ST_INSTR_RD_DN;
            end
            ST_INSTR_RD_DN: begin
                instrBlkValid = memRdValid;
                if (memRdValid) nextState = ST_IDLE;
            end

            ST_DATA_RD: begin
                memOp   = OP_READ;
                memAddr = dataAddr & BLK_MASK;
                if (memDone) nextState = ST_DATA_RD_DN;
            end
            ST_DATA_RD_DN: begin
                dataBlkValid = memRdValid;
                if (memRdValid) nextState = ST_IDLE;
            end

            ST_DATA_WR: begin
                memOp     = OP_WRITE;
                memAddr   = dataAddr & BLK_MASK;
                memWrData = dataWrBlk;
                if (memDone) nextState = ST_DATA_WR_DN;
            end
            ST_DATA_WR_DN: begin
                dataEvictAck = 1'b1;   // single cycle ack
                nextState    = ST_IDLE;
            end

            // chunk into the accel buffer
            ST_ACCEL_RD: begin
                memOp   = OP_READ;
                memAddr = blkAddr & BLK_MASK;
                if (memDone) nextState = ST_ACCEL_RD_DN;
            end
            ST_ACCEL_RD_DN: begin
                if (memRdValid) begin
                    accelRdBlkDone = 1'b1;
                    blkStep        = 1'b1;
                    accelChunkDone = lastBlk;
                    chunkClear     = lastBlk;
                    nextState      = lastBlk ? ST_IDLE : ST_ACCEL_RD;   // no idle between blocks
                end
            end

            // chunk out of the accel buffer
            ST_ACCEL_WR: begin
                memOp     = OP_WRITE;
                memAddr   = blkAddr & BLK_MASK;
                memWrData = accelWrBlk;
                if (memDone) nextState = ST_ACCEL_WR_DN;
            end
            ST_ACCEL_WR_DN: begin
                accelWrBlkDone = 1'b1;
                blkStep        = 1'b1;
                accelChunkDone = lastBlk;
                chunkClear     = lastBlk;
                nextState      = lastBlk ? ST_IDLE : ST_ACCEL_WR;
            end

            default: begin
                nextState = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= nextState;
        end
    end

endmodule

/* hw/sigTable.sv */
`timescale 1ns/100ps
`include "memArb_consts.svh"

module sigTable (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    tableWr,     // load strobe
    input  logic [`SIG_BITS-1:0]    tableSig,    // entry being loaded
    input  logic [`BLKNUM_BITS-1:0] tableStart,  // start block for that entry
    input  logic [`SIG_BITS-1:0]    sigNum,      // entry used by the current chunk
    input  logic                    blkStep,
    input  logic                    chunkClear,
    output logic [31:0]             blkAddr,
    output logic                    lastBlk
);

    localparam int NUM_SIGS = 1 << `SIG_BITS;
    localparam int OFF_BITS = $clog2(`CHUNK_BLKS);

    logic [`BLKNUM_BITS-1:0] startTbl [NUM_SIGS];   // start block per signal
    logic [OFF_BITS-1:0]     blkOffset;             // block within chunk
    logic [`BLKNUM_BITS-1:0] curBlk;

    // table load, contents undefined until written
    always_ff @(posedge clk) begin
        if (tableWr) begin
            startTbl[tableSig] <= tableStart;
        end
    end

    // chunk offset counter
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            blkOffset <= '0;
        end else if (chunkClear) begin
            blkOffset <= '0;                  // clear wins over step
        end else if (blkStep) begin
            blkOffset <= blkOffset + 1'b1;
        end
    end

    // start block plus offset, then scale by 64 bytes
    assign curBlk  = startTbl[sigNum] + `BLKNUM_BITS'(blkOffset);
    assign blkAddr = `SIG_BASE + {curBlk, 6'b0};
    assign lastBlk = (blkOffset == OFF_BITS'(`CHUNK_BLKS - 1));

endmodule

/* hw/bankIf.sv */
`timescale 1ns/100ps
`include "memArb_consts.svh"

interface bankIf import memPkg::*; ();

    localparam int ROW_BITS = $clog2(`BANK_ROWS);

    memOp_t              op;       // idle unless this bank is selected
    logic [ROW_BITS-1:0] row;
    blk_t                wrData;
    blk_t                rdData;   // valid with rdValid only
    logic                done;     // one cycle pulse
    logic                rdValid;  // one cycle after done, reads only

    modport router (output op, row, wrData);
    modport bank   (input op, row, wrData, output rdData, done, rdValid);
    modport merge  (input rdData, done, rdValid);

endinterface

/* hw/memPkg.sv */
`include "memArb_consts.svh"

package memPkg;

    // shared block port opcode
    typedef enum logic [1:0] {
        OP_IDLE  = 2'b00,
        OP_READ  = 2'b01,
        OP_WRITE = 2'b11
    } memOp_t;

    // arbiter states, request state then done state per access
    typedef enum logic [3:0] {
        ST_IDLE        = 4'h0,
        ST_INSTR_RD    = 4'h1,
        ST_INSTR_RD_DN = 4'h2,
        ST_DATA_RD     = 4'h3,
        ST_DATA_RD_DN  = 4'h4,
        ST_DATA_WR     = 4'h5,
        ST_DATA_WR_DN  = 4'h6,
        ST_ACCEL_RD    = 4'h7,
        ST_ACCEL_RD_DN = 4'h8,
        ST_ACCEL_WR    = 4'h9,
        ST_ACCEL_WR_DN = 4'hA
    } arbState_t;

    typedef logic [`BLK_BITS-1:0] blk_t;   // one block of payload

endpackage

/* hw/memArb_consts.svh */
`ifndef MEMARB_CONSTS_SVH
`define MEMARB_CONSTS_SVH

`define BLK_BITS    512             // one 64 byte block
`define NUM_BANKS   4               // bank select is addr[7:6]
`define BANK_ROWS   16              // row is addr[11:8]
`define BANK_LAT    3               // access start to done pulse, in cycles
`define CHUNK_BLKS  4               // blocks per accel chunk

// signal table sizing
`define SIG_BITS    3               // 8 table entries
`define BLKNUM_BITS 26              // block number, addr[31:6]
`define SIG_BASE    32'h1000_0000   // base of the signal region

`endif
